/* src/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // ********************
  // array geometry
  // ********************

  localparam int DATA_W = 15;
  localparam int ADDR_W = 8;
  localparam int DEPTH  = 1 << ADDR_W;  // 256 words

  localparam int NUM_RD = 3;
  localparam int NUM_WR = 2;

  // ********************
  // types
  // ********************

  typedef logic [DATA_W-1:0] data_t;  // a word or a bit-write mask of the same width
  typedef logic [ADDR_W-1:0] addr_t;

  // read pipeline occupancy in the core
  typedef enum logic [1:0] {
    idle,
    busy,
    drain
  } rd_pipe_state_t;

endpackage

`default_nettype wire

/* src/mem_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one write port whose strobe and payload are valid in the same cycle
interface wr_port_if;
  logic               write;
  mem_pkg::addr_t     addr;
  mem_pkg::data_t     din;
  mem_pkg::data_t     bw;

  modport src (output write, addr, din, bw);
  modport dst (input  write, addr, din, bw);
endinterface

// one read lane from the core out to the top level
interface rd_lane_if;
  logic               req;   // read strobe after the core latency
  mem_pkg::data_t     data;  // array word returned with req
  logic               vld;
  mem_pkg::data_t     dout;

  modport core (
    output req,
    output data
  );

  modport lane (
    input  req,
    input  data,
    output vld,
    output dout
  );
endinterface

`default_nettype wire

/* src/mem_port_wrap.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_port_wrap #(
  parameter int FLOPIN = 1
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mem_pkg::NUM_RD-1:0]                    read,
  input  logic [mem_pkg::NUM_RD*mem_pkg::ADDR_W-1:0]    rd_adr,
  input  logic [mem_pkg::NUM_WR-1:0]                    write,
  input  logic [mem_pkg::NUM_WR*mem_pkg::ADDR_W-1:0]    wr_adr,
  input  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    din,
  input  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    bw,
  output logic [mem_pkg::NUM_RD-1:0]                    rd_req,
  output mem_pkg::addr_t                                rd_addr [mem_pkg::NUM_RD],
  wr_port_if.src                                        wr_port [mem_pkg::NUM_WR]
);

  mem_pkg::addr_t                rd_addr_s [mem_pkg::NUM_RD];
  mem_pkg::addr_t                wr_addr_s [mem_pkg::NUM_WR];
  mem_pkg::data_t                din_s     [mem_pkg::NUM_WR];
  mem_pkg::data_t                bw_s      [mem_pkg::NUM_WR];

  logic [mem_pkg::NUM_WR-1:0]    wr_en_o;
  mem_pkg::addr_t                wr_addr_o [mem_pkg::NUM_WR];
  mem_pkg::data_t                din_o     [mem_pkg::NUM_WR];
  mem_pkg::data_t                bw_o      [mem_pkg::NUM_WR];

  // ********************
  // slice the flat buses with port 0 in the low bits
  // ********************

  for (genvar r = 0; r < mem_pkg::NUM_RD; r++) begin : g_rd_slice
    assign rd_addr_s[r] = rd_adr[r*mem_pkg::ADDR_W +: mem_pkg::ADDR_W];
  end

  for (genvar p = 0; p < mem_pkg::NUM_WR; p++) begin : g_wr_slice
    assign wr_addr_s[p] = wr_adr[p*mem_pkg::ADDR_W +: mem_pkg::ADDR_W];
    assign din_s[p]     = din[p*mem_pkg::DATA_W +: mem_pkg::DATA_W];
    assign bw_s[p]      = bw[p*mem_pkg::DATA_W +: mem_pkg::DATA_W];
  end

  // ********************
  // optional input stage
  // ********************

  if (FLOPIN > 0) begin : g_flopin
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        rd_req  <= '0;
        wr_en_o <= '0;
      end else begin
        rd_req  <= read;
        wr_en_o <= write;
      end
    end

    // payload moves together with its strobe
    always_ff @(posedge clk) begin
      rd_addr   <= rd_addr_s;
      wr_addr_o <= wr_addr_s;
      din_o     <= din_s;
      bw_o      <= bw_s;
    end
  end else begin : g_noflopin
    always_comb begin
      rd_req    = read;
      rd_addr   = rd_addr_s;
      wr_en_o   = write;
      wr_addr_o = wr_addr_s;
      din_o     = din_s;
      bw_o      = bw_s;
    end
  end

  for (genvar p = 0; p < mem_pkg::NUM_WR; p++) begin : g_wr_drive
    assign wr_port[p].write = wr_en_o[p];
    assign wr_port[p].addr  = wr_addr_o[p];
    assign wr_port[p].din   = din_o[p];
    assign wr_port[p].bw    = bw_o[p];
  end

endmodule

`default_nettype wire

/* src/mem_core_3r2w.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_core_3r2w #(
  parameter int SRAM_DELAY = 2
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [mem_pkg::NUM_RD-1:0]   rd_req,
  input  mem_pkg::addr_t               rd_addr [mem_pkg::NUM_RD],
  wr_port_if.dst                       wr_port [mem_pkg::NUM_WR],
  rd_lane_if.core                      lane    [mem_pkg::NUM_RD]
);

  mem_pkg::data_t                mem       [mem_pkg::DEPTH];

  logic [mem_pkg::NUM_WR-1:0]    wr_en;
  mem_pkg::addr_t                wr_addr   [mem_pkg::NUM_WR];
  mem_pkg::data_t                wr_din    [mem_pkg::NUM_WR];
  mem_pkg::data_t                wr_bw     [mem_pkg::NUM_WR];
  mem_pkg::data_t                wr_word   [mem_pkg::NUM_WR];

  logic [mem_pkg::NUM_RD-1:0]    vld_pipe  [SRAM_DELAY];
  mem_pkg::data_t                data_pipe [SRAM_DELAY][mem_pkg::NUM_RD];

  mem_pkg::rd_pipe_state_t       state;
  mem_pkg::rd_pipe_state_t       state_nxt;
  logic                          in_flight;
  logic                          pipe_en;

  for (genvar p = 0; p < mem_pkg::NUM_WR; p++) begin : g_wr_in
    assign wr_en[p]   = wr_port[p].write;
    assign wr_addr[p] = wr_port[p].addr;
    assign wr_din[p]  = wr_port[p].din;
    assign wr_bw[p]   = wr_port[p].bw;
  end

  // ********************
  // masked writes
  // ********************

  // each port folds in the lower ports that hit the same word, so the
  // highest port written last carries every enabled bit
  always_comb begin
    for (int p = 0; p < mem_pkg::NUM_WR; p++) begin
      wr_word[p] = mem[wr_addr[p]];
      for (int q = 0; q <= p; q++) begin
        if (wr_en[q] && (wr_addr[q] == wr_addr[p])) begin
          wr_word[p] = (wr_word[p] & ~wr_bw[q]) | (wr_din[q] & wr_bw[q]);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < mem_pkg::NUM_WR; p++) begin
      if (wr_en[p]) mem[wr_addr[p]] <= wr_word[p];
    end
  end

  // ********************
  // read pipeline
  // ********************

  always_comb begin
    in_flight = 1'b0;
    for (int s = 0; s < SRAM_DELAY - 1; s++) in_flight = in_flight | (|vld_pipe[s]);
    if (|rd_req)        state_nxt = mem_pkg::busy;
    else if (in_flight) state_nxt = mem_pkg::drain;  // older reads still moving
    else                state_nxt = mem_pkg::idle;
  end

  assign pipe_en = (state != mem_pkg::idle) || (|rd_req);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= mem_pkg::idle;
      for (int s = 0; s < SRAM_DELAY; s++) vld_pipe[s] <= '0;
    end else begin
      state <= state_nxt;
      if (pipe_en) begin
        vld_pipe[0] <= rd_req;
        for (int s = 1; s < SRAM_DELAY; s++) vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  // the array is sampled here before this edge's writes land
  always_ff @(posedge clk) begin
    if (pipe_en) begin
      for (int r = 0; r < mem_pkg::NUM_RD; r++) begin
        if (rd_req[r]) data_pipe[0][r] <= mem[rd_addr[r]];
        for (int s = 1; s < SRAM_DELAY; s++) begin
          if (vld_pipe[s-1][r]) data_pipe[s][r] <= data_pipe[s-1][r];
        end
      end
    end
  end

  for (genvar r = 0; r < mem_pkg::NUM_RD; r++) begin : g_lane_out
    assign lane[r].req  = vld_pipe[SRAM_DELAY-1][r];
    assign lane[r].data = data_pipe[SRAM_DELAY-1][r];
  end

endmodule

`default_nettype wire

/* src/rd_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_lane #(
  parameter int FLOPOUT = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  rd_lane_if.lane    lane
);

  if (FLOPOUT == 0) begin : g_pass

    // without output stages the core strobe and word go straight out
    assign lane.vld  = lane.req;
    assign lane.dout = lane.data;

  end else begin : g_flop

    logic [FLOPOUT-1:0]  vld_q;
    mem_pkg::data_t      dout_q [FLOPOUT];

    // ********************
    // valid shift
    // ********************

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= lane.req;
        for (int s = 1; s < FLOPOUT; s++) begin
          vld_q[s] <= vld_q[s-1];
        end
      end
    end

    // ********************
    // data shift
    // ********************

    // each stage holds its word until a new valid one arrives
    always_ff @(posedge clk) begin
      if (lane.req) dout_q[0] <= lane.data;
      for (int s = 1; s < FLOPOUT; s++) begin
        if (vld_q[s-1]) begin
          dout_q[s] <= dout_q[s-1];
        end
      end
    end

    assign lane.vld  = vld_q[FLOPOUT-1];
    assign lane.dout = dout_q[FLOPOUT-1];  // meaningful only with vld

  end

endmodule

`default_nettype wire

/* src/mem_3r2w_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_3r2w_top #(
  parameter int FLOPIN     = 1,
  parameter int SRAM_DELAY = 2,
  parameter int FLOPOUT    = 1
) (
  input  logic                                          clk,
  input  logic                                          rst_n,

  input  logic [mem_pkg::NUM_RD-1:0]                    read,
  input  logic [mem_pkg::NUM_RD*mem_pkg::ADDR_W-1:0]    rd_adr,
  output logic [mem_pkg::NUM_RD*mem_pkg::DATA_W-1:0]    rd_dout,
  output logic [mem_pkg::NUM_RD-1:0]                    rd_vld,

  input  logic [mem_pkg::NUM_WR-1:0]                    write,
  input  logic [mem_pkg::NUM_WR*mem_pkg::ADDR_W-1:0]    wr_adr,
  input  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    din,
  input  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    bw
);

  logic [mem_pkg::NUM_RD-1:0]    rd_req;
  mem_pkg::addr_t                rd_addr [mem_pkg::NUM_RD];

  wr_port_if  wr_port [mem_pkg::NUM_WR] ();
  rd_lane_if  lane    [mem_pkg::NUM_RD] ();

  // ********************
  // request side
  // ********************

  mem_port_wrap #(
    .FLOPIN     (FLOPIN)
  ) mem_port_wrap_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .read       (read),
    .rd_adr     (rd_adr),
    .write      (write),
    .wr_adr     (wr_adr),
    .din        (din),
    .bw         (bw),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .wr_port    (wr_port)
  );

  // ********************
  // storage
  // ********************

  mem_core_3r2w #(
    .SRAM_DELAY (SRAM_DELAY)
  ) mem_core_3r2w_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .wr_port    (wr_port),
    .lane       (lane)
  );

  // ********************
  // read lanes
  // ********************

  // total read latency is FLOPIN + SRAM_DELAY + FLOPOUT
  for (genvar i = 0; i < mem_pkg::NUM_RD; i++) begin : g_lane
    rd_lane #(
      .FLOPOUT  (FLOPOUT)
    ) rd_lane_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .lane     (lane[i])
    );

    assign rd_vld[i] = lane[i].vld;
    assign rd_dout[i*mem_pkg::DATA_W +: mem_pkg::DATA_W] = lane[i].dout;  // port 0 low
  end

endmodule

`default_nettype wire

/* test/mem_3r2w_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_3r2w_checker #(
  parameter int LAT = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [mem_pkg::NUM_RD-1:0]                    read,
  input  logic [mem_pkg::NUM_RD*mem_pkg::ADDR_W-1:0]    rd_adr,
  input  logic [mem_pkg::NUM_WR-1:0]                    write,
  input  logic [mem_pkg::NUM_WR*mem_pkg::ADDR_W-1:0]    wr_adr,
  input  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    din,
  input  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    bw,
  input  logic [mem_pkg::NUM_RD*mem_pkg::DATA_W-1:0]    rd_dout,
  input  logic [mem_pkg::NUM_RD-1:0]                    rd_vld,
  output int                                            errors,
  output int                                            compares
);

  mem_pkg::data_t                ref_mem  [mem_pkg::DEPTH];
  mem_pkg::data_t                known    [mem_pkg::DEPTH];  // bits written at least once

  // expected responses where entry LAT-1 is due at the outputs this cycle
  logic [mem_pkg::NUM_RD-1:0]    vld_dl   [LAT];
  mem_pkg::data_t                word_dl  [LAT][mem_pkg::NUM_RD];
  mem_pkg::data_t                known_dl [LAT][mem_pkg::NUM_RD];

  always @(posedge clk) begin : model
    mem_pkg::addr_t  a;
    mem_pkg::data_t  m;
    mem_pkg::data_t  act;
    mem_pkg::data_t  exp;

    if (!rst_n) begin
      errors   = 0;
      compares = 0;
      for (int i = 0; i < mem_pkg::DEPTH; i++) begin
        ref_mem[i] = '0;
        known[i]   = '0;
      end
      for (int s = 0; s < LAT; s++) vld_dl[s] = '0;
    end else begin

      // ********************
      // compare outputs
      // ********************

      if (rd_vld !== vld_dl[LAT-1]) begin
        errors++;
        $display("Mismatch at time %0t: rd_vld expected %b actual %b",
                 $time, vld_dl[LAT-1], rd_vld);
      end
      for (int r = 0; r < mem_pkg::NUM_RD; r++) begin
        if (vld_dl[LAT-1][r] && rd_vld[r] && (known_dl[LAT-1][r] != '0)) begin
          act = rd_dout[r*mem_pkg::DATA_W +: mem_pkg::DATA_W] & known_dl[LAT-1][r];
          exp = word_dl[LAT-1][r] & known_dl[LAT-1][r];
          compares++;
          if (act !== exp) begin
            errors++;
            $display("Mismatch at time %0t: rd_dout[%0d] expected %h actual %h",
                     $time, r, exp, act);
          end
        end
      end

      // ********************
      // advance the model
      // ********************

      for (int s = LAT - 1; s > 0; s--) begin
        vld_dl[s]   = vld_dl[s-1];
        word_dl[s]  = word_dl[s-1];
        known_dl[s] = known_dl[s-1];
      end

      // reads see the array as it was before this cycle's writes
      for (int r = 0; r < mem_pkg::NUM_RD; r++) begin
        a = rd_adr[r*mem_pkg::ADDR_W +: mem_pkg::ADDR_W];
        vld_dl[0][r]   = read[r];
        word_dl[0][r]  = ref_mem[a];
        known_dl[0][r] = known[a];
      end

      for (int p = 0; p < mem_pkg::NUM_WR; p++) begin  // port 1 goes last and wins the overlap
        if (write[p]) begin
          a = wr_adr[p*mem_pkg::ADDR_W +: mem_pkg::ADDR_W];
          m = bw[p*mem_pkg::DATA_W +: mem_pkg::DATA_W];
          ref_mem[a] = (ref_mem[a] & ~m) | (din[p*mem_pkg::DATA_W +: mem_pkg::DATA_W] & m);
          known[a]   = known[a] | m;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* test/mem_3r2w_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_3r2w_tb;

  localparam int FLOPIN     = 1;
  localparam int SRAM_DELAY = 2;
  localparam int FLOPOUT    = 1;
  localparam int LAT        = FLOPIN + SRAM_DELAY + FLOPOUT;
  localparam int RESET_CYC  = 8;
  localparam int DRAIN      = LAT + 4;
  localparam int T1_LEN     = 48;
  localparam int T2_LEN     = 128 + 256;
  localparam int T3_LEN     = 2000;
  localparam int T4_LEN     = 64;
  localparam int T5_LEN     = 60;
  localparam int LIMIT      = RESET_CYC + T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN
                              + 5 * DRAIN + 100;

  logic                                          clk = 1'b0;
  logic                                          rst_n;
  logic [mem_pkg::NUM_RD-1:0]                    read, nx_read;
  logic [mem_pkg::NUM_RD*mem_pkg::ADDR_W-1:0]    rd_adr, nx_rd_adr;
  logic [mem_pkg::NUM_WR-1:0]                    write, nx_write;
  logic [mem_pkg::NUM_WR*mem_pkg::ADDR_W-1:0]    wr_adr, nx_wr_adr;
  logic [mem_pkg::NUM_WR*mem_pkg::DATA_W-1:0]    din, nx_din, bw, nx_bw;
  logic [mem_pkg::NUM_RD*mem_pkg::DATA_W-1:0]    rd_dout;
  logic [mem_pkg::NUM_RD-1:0]                    rd_vld;
  logic [31:0]                                   rng_state;
  int                                            err_total, cmp_total, test_base;
  int                                            cycle_cnt = 0;

  always #2 clk = ~clk;

  mem_3r2w_top #(
    .FLOPIN     (FLOPIN),
    .SRAM_DELAY (SRAM_DELAY),
    .FLOPOUT    (FLOPOUT)
  ) mem_3r2w_top_inst (
    .clk(clk), .rst_n(rst_n), .read(read), .rd_adr(rd_adr), .rd_dout(rd_dout),
    .rd_vld(rd_vld), .write(write), .wr_adr(wr_adr), .din(din), .bw(bw)
  );

  mem_3r2w_checker #(
    .LAT (LAT)
  ) mem_3r2w_checker_inst (
    .clk(clk), .rst_n(rst_n), .read(read), .rd_adr(rd_adr), .write(write),
    .wr_adr(wr_adr), .din(din), .bw(bw), .rd_dout(rd_dout), .rd_vld(rd_vld),
    .errors(err_total), .compares(cmp_total)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("Finished with errors");
      $finish;
    end
  end

  // ********************
  // stimulus helpers
  // ********************

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic set_read(input int port, input mem_pkg::addr_t a);
    nx_read[port] = 1'b1;
    nx_rd_adr[port*mem_pkg::ADDR_W +: mem_pkg::ADDR_W] = a;
  endtask

  task automatic set_write(input int port, input mem_pkg::addr_t a,
                           input mem_pkg::data_t d, input mem_pkg::data_t m);
    nx_write[port] = 1'b1;
    nx_wr_adr[port*mem_pkg::ADDR_W +: mem_pkg::ADDR_W] = a;
    nx_din[port*mem_pkg::DATA_W +: mem_pkg::DATA_W]    = d;
    nx_bw[port*mem_pkg::DATA_W +: mem_pkg::DATA_W]     = m;
  endtask

  task automatic step_cycle();
    @(posedge clk);
    read   <= nx_read;
    rd_adr <= nx_rd_adr;
    write  <= nx_write;
    wr_adr <= nx_wr_adr;
    din    <= nx_din;
    bw     <= nx_bw;
    nx_read  = '0;  // strobes last one cycle unless set again
    nx_write = '0;
  endtask

  task automatic end_test(input int num, input string name);
    repeat (DRAIN) step_cycle();
    @(negedge clk);
    $display("test %0d (%s): %0d errors", num, name, err_total - test_base);
    test_base = err_total;
  endtask

  initial begin
    logic [31:0]     r;
    mem_pkg::addr_t  a;
    mem_pkg::data_t  m0;

    rst_n = 1'b0;
    {read, rd_adr, write, wr_adr, din, bw} = '0;
    {nx_read, nx_rd_adr, nx_write, nx_wr_adr, nx_din, nx_bw} = '0;
    rng_state = 32'd60750;
    test_base = 0;
    repeat (RESET_CYC) @(posedge clk);
    rst_n <= 1'b1;

    // random strobes with a back-to-back burst in 16..27 and an idle gap until 36
    for (int c = 0; c < T1_LEN; c++) begin
      r = next_rand();
      for (int p = 0; p < mem_pkg::NUM_RD; p++) begin
        if ((c >= 16 && c < 28) || (c < 16 && r[p]) || (c >= 36 && r[p+8]))
          set_read(p, mem_pkg::addr_t'(r[31:24]));
      end
      step_cycle();
    end
    end_test(1, "rd_vld timing");

    for (int c = 0; c < 128; c++) begin
      set_write(0, mem_pkg::addr_t'(2 * c), mem_pkg::data_t'(next_rand()), '1);
      set_write(1, mem_pkg::addr_t'(2 * c + 1), mem_pkg::data_t'(next_rand()), '1);
      step_cycle();
    end
    for (int c = 0; c < mem_pkg::DEPTH; c++) begin
      for (int p = 0; p < mem_pkg::NUM_RD; p++) set_read(p, mem_pkg::addr_t'(c));
      step_cycle();
    end
    end_test(2, "fill and read back");

    for (int c = 0; c < T3_LEN; c++) begin
      for (int p = 0; p < mem_pkg::NUM_RD + mem_pkg::NUM_WR; p++) begin
        r = next_rand();
        a = r[1] ? mem_pkg::addr_t'(r[5:2]) : mem_pkg::addr_t'(r[15:8]);  // narrow window
        if (r[0] && p < mem_pkg::NUM_RD) set_read(p, a);
        if (r[0] && p >= mem_pkg::NUM_RD)
          set_write(p - mem_pkg::NUM_RD, a, mem_pkg::data_t'(next_rand()),
                    mem_pkg::data_t'(next_rand()));
      end
      step_cycle();
    end
    end_test(3, "random traffic");

    for (int c = 0; c < T4_LEN / 2; c++) begin
      a  = mem_pkg::addr_t'(next_rand());
      m0 = mem_pkg::data_t'(next_rand()) | 15'h0101;
      set_write(0, a, mem_pkg::data_t'(next_rand()), m0);
      set_write(1, a, mem_pkg::data_t'(next_rand()), mem_pkg::data_t'(next_rand()) | 15'h0180);
      step_cycle();
      for (int p = 0; p < mem_pkg::NUM_RD; p++) set_read(p, a);
      step_cycle();
    end
    end_test(4, "same address writes");

    for (int c = 0; c < T5_LEN / 3; c++) begin
      a = mem_pkg::addr_t'(next_rand());
      set_write(c % 2, a, mem_pkg::data_t'(next_rand()), '1);
      for (int p = 0; p < mem_pkg::NUM_RD; p++) set_read(p, a);
      step_cycle();
      for (int p = 0; p < mem_pkg::NUM_RD; p++) set_read(p, a);
      step_cycle();
      step_cycle();
    end
    end_test(5, "read during write");

    $display("totals: 5 tests, %0d data compares, %0d errors", cmp_total, err_total);
    if (err_total == 0 && cmp_total > 0) begin
      $display("Finished with no errors");
    end else begin
      if (cmp_total == 0) $display("no read data was ever compared");
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/mem_pkg.sv
src/mem_port_if.sv
src/mem_port_wrap.sv
src/mem_core_3r2w.sv
src/rd_lane.sv
src/mem_3r2w_top.sv
test/mem_3r2w_checker.sv
test/mem_3r2w_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it, and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -Wno-fatal --top-module mem_3r2w_tb -Mdir obj_dir -f filelist.f \
  && ./obj_dir/Vmem_3r2w_tb | tee "$LOG" \
  || { echo "build or simulation failed"; exit 1; }

grep -q "Finished with no errors" "$LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }
